// ==== cpu_board_bus.f ====
rtl/board_pkg.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
rtl/block_memory.sv
rtl/ps2_keyboard.sv
rtl/uart_tx.sv
rtl/cpu_board_bus.sv
verification/cpu_board_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f cpu_board_bus.f --top-module cpu_board_bus_tb \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST PASS" sim.log || echo "TEST FAIL" >> sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== rom.hex ====
// boot words at 0x000 to 0x03c, one 32-bit word per line
00001137
00000093
00000193
00000213
00000293
00000313
00000393
00000413
000034b7
00010537
0044a583
0005a603
00c52023
00450513
fe5ff06f
00000013

// ==== verification/cpu_board_bus_tb.sv ====
`timescale 1ns/10ps

module cpu_board_bus_tb import board_pkg::*; ();

    localparam int cpb = 16;
    localparam int ack_limit = 400;

    logic    CLOCK_50;
    logic    KEY0;
    wb_req_t fetch_req;
    wb_req_t data_req;
    wb_rsp_t fetch_rsp;
    wb_rsp_t data_rsp;
    logic    PS2_CLK;
    logic    PS2_DAT;
    logic    UART_TXD;
    logic    IRQ;

    int          errors;
    int          cycle;
    logic [31:0] rom_model [0:15];
    logic [31:0] ram_model [0:31];
    logic [7:0]  key_model;
    logic        pending_model;
    logic        armed_model;
    logic [7:0]  sent_q [$];
    logic [7:0]  rx_q [$];

    cpu_board_bus #(.mem_words(3072), .clks_per_bit(cpb)) i_cpu_board_bus (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .PS2_CLK   (PS2_CLK),
        .PS2_DAT   (PS2_DAT),
        .UART_TXD  (UART_TXD),
        .IRQ       (IRQ)
    );

    always #4 CLOCK_50 = ~CLOCK_50;

    // cycle count, read only on falling edges
    always @(posedge CLOCK_50) begin
        cycle = cycle + 1;
    end

    task automatic end_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one wishbone classic transfer on the fetch or data port
    task automatic bus_xfer(input bit use_data, input bit we, input logic [31:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat,
                            output int ack_cycle);
        wb_req_t r;
        wb_rsp_t rsp;
        int      waited;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = adr;
        r.dat = wdat;
        @(negedge CLOCK_50);
        if (use_data) begin
            data_req = r;
        end else begin
            fetch_req = r;
        end
        waited = 0;
        do begin
            @(negedge CLOCK_50);
            rsp = use_data ? data_rsp : fetch_rsp;
            waited++;
        end while (!rsp.ack && waited < ack_limit);
        rdat      = rsp.dat;
        ack_cycle = cycle;
        if (!rsp.ack) begin
            errors++;
            $display("master %0d got no ack for address %h in time", use_data, adr);
            end_run();
        end else begin
            // request stays up through the ack cycle
            @(negedge CLOCK_50);
            rsp = use_data ? data_rsp : fetch_rsp;
            // ack is a single pulse
            if (rsp.ack) begin
                errors++;
                $display("master %0d saw a second ack for address %h", use_data, adr);
            end
            if (use_data) begin
                data_req = '0;
            end else begin
                fetch_req = '0;
            end
        end
    endtask

    // 11 bit frame with data changing while the clock is high
    task automatic ps2_send(input logic [7:0] code, input bit bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge CLOCK_50);
            PS2_DAT = frame[i];
            repeat (20) @(negedge CLOCK_50);
            PS2_CLK = 1'b0;
            repeat (20) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
        end
        repeat (20) @(negedge CLOCK_50);
        // reference filter
        if (!bad_parity) begin
            if (armed_model) begin
                armed_model = 1'b0;
            end else if (code == 8'hF0) begin
                armed_model = 1'b1;
            end else begin
                key_model     = code;
                pending_model = 1'b1;
            end
        end
        check_value("irq", 32'(pending_model), 32'(IRQ));
    endtask

    // samples each bit near its center
    task automatic uart_capture(input int n);
        logic [7:0] b;
        int         waited;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            while (UART_TXD !== 1'b0 && waited < 1000) begin
                @(negedge CLOCK_50);
                waited++;
            end
            if (UART_TXD !== 1'b0) begin
                errors++;
                $display("uart start bit %0d never came", k);
                end_run();
            end else begin
                repeat (cpb / 2) @(negedge CLOCK_50);
                check_value("uart start", 32'h0, 32'(UART_TXD));
                for (int i = 0; i < 8; i++) begin
                    repeat (cpb) @(negedge CLOCK_50);
                    b[i] = UART_TXD;
                end
                repeat (cpb) @(negedge CLOCK_50);
                check_value("uart stop", 32'h1, 32'(UART_TXD));
                rx_q.push_back(b);
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] adr;
        logic [7:0]  code;
        int          ac;
        int          last_ack;
        int          idx;
        int          kind;
        int          polls;

        CLOCK_50      = 1'b0;
        KEY0          = 1'b0;
        fetch_req     = '0;
        data_req      = '0;
        PS2_CLK       = 1'b1;
        PS2_DAT       = 1'b1;
        errors        = 0;
        cycle         = 0;
        key_model     = 8'h00;
        pending_model = 1'b0;
        armed_model   = 1'b0;
        void'($urandom(32'h8606));
        $readmemh("rom.hex", rom_model);
        repeat (10) @(negedge CLOCK_50);
        KEY0 = 1'b1;

        // fill the ram window so every model word is known
        for (int i = 0; i < 32; i++) begin
            ram_model[i] = $urandom;
            bus_xfer(1, 1, 32'h1000 + i * 32'h100, ram_model[i], rd, ac);
        end

        // memory behavior
        for (int n = 0; n < 80; n++) begin
            kind = $urandom % 5;
            idx  = $urandom % 32;
            case (kind)
                0: begin
                    ram_model[idx] = $urandom;
                    bus_xfer(1, 1, 32'h1000 + idx * 32'h100, ram_model[idx], rd, ac);
                end
                1: begin
                    bus_xfer(1, 0, 32'h1000 + idx * 32'h100, 0, rd, ac);
                    check_value("ram read", ram_model[idx], rd);
                end
                2: begin
                    // rom write is dropped
                    bus_xfer(1, 1, (idx % 16) * 4, $urandom, rd, ac);
                    bus_xfer(1, 0, (idx % 16) * 4, 0, rd, ac);
                    check_value("rom after write", rom_model[idx % 16], rd);
                end
                3: begin
                    bus_xfer(1, 0, (idx % 16) * 4, 0, rd, ac);
                    check_value("rom read", rom_model[idx % 16], rd);
                end
                default: begin
                    adr = 32'h0001_0000 + ($urandom % 256) * 4;
                    bus_xfer(1, 1, adr, $urandom, rd, ac);
                    bus_xfer(1, 0, adr, 0, rd, ac);
                    check_value("unmapped read", 32'h0, rd);
                end
            endcase
        end

        // both masters at once with fetch kept in rom
        fork
            begin
                logic [31:0] frd;
                int          fac;
                int          fi;
                for (int n = 0; n < 60; n++) begin
                    fi = $urandom % 16;
                    bus_xfer(0, 0, fi * 4, 0, frd, fac);
                    check_value("fetch read", rom_model[fi], frd);
                end
            end
            begin
                logic [31:0] drd;
                int          dac;
                int          di;
                for (int n = 0; n < 60; n++) begin
                    di = $urandom % 32;
                    if ($urandom % 2) begin
                        ram_model[di] = $urandom;
                        bus_xfer(1, 1, 32'h1000 + di * 32'h100, ram_model[di], drd, dac);
                    end else begin
                        bus_xfer(1, 0, 32'h1000 + di * 32'h100, 0, drd, dac);
                        check_value("data read", ram_model[di], drd);
                    end
                end
            end
        join

        // keyboard filter and interrupt clearing
        for (int n = 0; n < 12; n++) begin
            code = 8'($urandom);
            if (code == 8'hF0) begin
                code = 8'h1C;
            end
            kind = $urandom % 3;
            if (kind == 1) begin
                ps2_send(8'hF0, 0);
            end
            ps2_send(code, kind == 2);
            if ($urandom % 2) begin
                // status mirrors the pending flag before the read
                bus_xfer(1, 0, key_stat_addr, 0, rd, ac);
                check_value("key status before read", 32'(pending_model), rd);
                bus_xfer(1, 0, key_data_addr, 0, rd, ac);
                check_value("key data", 32'(key_model), rd);
                pending_model = 1'b0;
                check_value("irq after read", 32'h0, 32'(IRQ));
                bus_xfer(1, 0, key_stat_addr, 0, rd, ac);
                check_value("key status", 32'h0, rd);
            end
        end

        // uart bytes back to back
        // each data write stalls while a frame is out
        fork
            uart_capture(6);
            begin
                last_ack = 0;
                for (int k = 0; k < 6; k++) begin
                    code = 8'($urandom);
                    sent_q.push_back(code);
                    bus_xfer(1, 1, uart_data_addr, 32'(code), rd, ac);
                    if (k > 0 && ac - last_ack < 10 * cpb) begin
                        errors++;
                        $display("uart write %0d acked while the frame was in progress", k);
                    end
                    last_ack = ac;
                    bus_xfer(1, 0, uart_stat_addr, 0, rd, ac);
                    check_value("uart busy", 32'h1, rd);
                end
            end
        join
        for (int k = 0; k < 6; k++) begin
            check_value("uart byte", 32'(sent_q[k]), 32'(rx_q[k]));
        end

        // busy drops once the last stop bit is out
        rd    = 32'h1;
        polls = 0;
        while (rd !== 32'h0 && polls < 50) begin
            bus_xfer(1, 0, uart_stat_addr, 0, rd, ac);
            polls++;
        end
        check_value("uart idle", 32'h0, rd);

        end_run();
    end

endmodule

// ==== rtl/cpu_board_bus.sv ====
`timescale 1ns/10ps

module cpu_board_bus import board_pkg::*; #(
    parameter int mem_words    = 3072,
    parameter int clks_per_bit = 16
) (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  wb_req_t fetch_req,
    output wb_rsp_t fetch_rsp,
    input  wb_req_t data_req,
    output wb_rsp_t data_rsp,
    input  logic    PS2_CLK,
    input  logic    PS2_DAT,
    output logic    UART_TXD,
    output logic    IRQ
);

    // shared bus after arbitration
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    // per slave ports
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;
    wb_req_t key_req;
    wb_rsp_t key_rsp;
    wb_req_t uart_req;
    wb_rsp_t uart_rsp;

    bus_arbiter i_bus_arbiter (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

    bus_decoder #(.mem_words(mem_words)) i_bus_decoder (
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .key_req  (key_req),
        .key_rsp  (key_rsp),
        .uart_req (uart_req),
        .uart_rsp (uart_rsp),
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    // boot rom and ram in one block
    block_memory #(.mem_words(mem_words)) i_block_memory (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (mem_req),
        .rsp      (mem_rsp)
    );

    ps2_keyboard i_ps2_keyboard (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (PS2_CLK),
        .ps2_dat  (PS2_DAT),
        .req      (key_req),
        .rsp      (key_rsp),
        .irq      (IRQ)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) i_uart_tx (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (uart_req),
        .rsp      (uart_rsp),
        .txd      (UART_TXD)
    );

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import board_pkg::*; #(
    parameter int clks_per_bit = 16
) (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  wb_req_t req,
    output wb_rsp_t rsp,
    output logic    txd
);

    localparam int cw = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    uart_state_e state;
    logic [cw-1:0] cnt;
    logic [3:0]    bit_cnt;
    logic [7:0]    shift;
    logic          bit_end;
    logic          busy;
    logic          is_data;
    logic          access;
    logic          ack;
    logic          start_tx;
    logic [31:0]   rd_data;

    assign busy    = (state != uart_idle);
    assign is_data = (req.adr == uart_data_addr);
    assign bit_end = (cnt == cw'(clks_per_bit - 1));

    // data writes wait for idle, everything else answers at once
    assign access = req.cyc && req.stb && !ack && (!(req.we && is_data) || !busy);

    // request is still held in the ack cycle
    assign start_tx = ack && req.we && is_data;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= uart_idle;
            cnt     <= '0;
            bit_cnt <= 4'd0;
            txd     <= 1'b1;
            ack     <= 1'b0;
        end else begin
            ack <= access;
            cnt <= (state == uart_idle || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                uart_idle: begin
                    txd <= 1'b1;
                    // start bit leaves right after the ack
                    if (start_tx) begin
                        txd     <= 1'b0;
                        bit_cnt <= 4'd0;
                        state   <= uart_data;
                    end
                end
                uart_data: begin
                    if (bit_end) begin
                        // eight data bits sent, move to stop
                        if (bit_cnt == 4'd8) begin
                            txd   <= 1'b1;
                            state <= uart_stop;
                        end else begin
                            txd     <= shift[0];
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                uart_stop: begin
                    if (bit_end) begin
                        state <= uart_done;
                    end
                end
                default: state <= uart_idle;
            endcase
        end
    end

    // byte shifts out lsb first
    always_ff @(posedge CLOCK_50) begin
        if (state == uart_idle && start_tx) begin
            shift <= req.dat[7:0];
        end else if (state == uart_data && bit_end) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    // data register reads back zero
    always_ff @(posedge CLOCK_50) begin
        if (access) begin
            rd_data <= is_data ? 32'h0 : {31'h0, busy};
        end
    end

    assign rsp.dat = rd_data;
    assign rsp.ack = ack;

endmodule

// ==== rtl/ps2_keyboard.sv ====
`timescale 1ns/10ps

module ps2_keyboard import board_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  logic    ps2_clk,
    input  logic    ps2_dat,
    input  wb_req_t req,
    output wb_rsp_t rsp,
    output logic    irq
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       fall;
    ps2_state_e state;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       parity;
    logic       frame_ok;
    logic       frame_end;
    logic       release_armed;
    logic       new_key;
    logic [7:0] key;
    logic       pending;
    logic       ack;
    logic       access;
    logic       is_data;
    logic       data_rd;
    logic [31:0] rd_data;

    // two flop synchronizer, lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // sample point is the falling edge of the device clock
    assign fall = clk_prev && !clk_sync[1];

    // stop bit high and odd parity over data plus parity bit
    assign frame_ok  = dat_sync[1] && (^{shift, parity});
    assign frame_end = fall && (state == ps2_done);

    // release prefix and the code after it never reach the key register
    assign new_key = frame_end && frame_ok && !release_armed && (shift != 8'hF0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= ps2_idle;
            bit_cnt <= 3'd0;
        end else if (fall) begin
            case (state)
                ps2_idle: begin
                    // start bit is low
                    if (!dat_sync[1]) begin
                        state   <= ps2_data;
                        bit_cnt <= 3'd0;
                    end
                end
                ps2_data: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= ps2_parity;
                    end
                end
                ps2_parity: state <= ps2_done;
                default:    state <= ps2_idle;
            endcase
        end
    end

    // frame payload, lsb first
    always_ff @(posedge CLOCK_50) begin
        if (fall && state == ps2_data) begin
            shift <= {dat_sync[1], shift[7:1]};
        end
        if (fall && state == ps2_parity) begin
            parity <= dat_sync[1];
        end
    end

    // bus side
    assign access  = req.cyc && req.stb && !ack;
    assign is_data = (req.adr == key_data_addr);
    assign data_rd = access && !req.we && is_data;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            release_armed <= 1'b0;
            key           <= 8'h00;
            pending       <= 1'b0;
            ack           <= 1'b0;
        end else begin
            ack <= access;
            // bad frames leave the filter as it was
            if (frame_end && frame_ok) begin
                release_armed <= release_armed ? 1'b0 : (shift == 8'hF0);
            end
            if (new_key) begin
                key <= shift;
            end
            // an arriving key beats the clearing read
            if (new_key) begin
                pending <= 1'b1;
            end else if (data_rd) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (access) begin
            rd_data <= is_data ? {24'h0, key} : {31'h0, pending};
        end
    end

    assign rsp.dat = rd_data;
    assign rsp.ack = ack;
    assign irq     = pending;

endmodule

// ==== rtl/block_memory.sv ====
`timescale 1ns/10ps

module block_memory import board_pkg::*; #(
    parameter int mem_words = 3072
) (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    localparam int aw = $clog2(mem_words);

    logic [31:0]   mem [0:mem_words-1];
    logic [aw-1:0] word_idx;
    logic [31:0]   rd_data;
    logic          ack;
    logic          access;
    logic          wr_en;

    // boot image at the bottom of the array
    initial begin
        $readmemh("rom.hex", mem, rom_base >> 2);
    end

    assign word_idx = req.adr[aw+1:2];

    // new access only, not again while stb is held
    assign access = req.cyc && req.stb && !ack;

    // rom words never change
    assign wr_en = access && req.we && (req.adr[31:2] >= ram_base[31:2]);

    // single port block ram, registered read
    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            mem[word_idx] <= req.dat;
        end
        rd_data <= mem[word_idx];
    end

    // one cycle ack pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    assign rsp.dat = rd_data;
    assign rsp.ack = ack;

endmodule

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder import board_pkg::*; #(
    parameter int mem_words = 3072
) (
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp,
    output wb_req_t key_req,
    input  wb_rsp_t key_rsp,
    output wb_req_t uart_req,
    input  wb_rsp_t uart_rsp,
    input  logic    CLOCK_50,
    input  logic    KEY0
);

    // end of the populated memory, in bytes
    localparam logic [31:0] mem_top = 32'(mem_words * 4);

    region_e region;
    logic    none_stb;
    logic    none_ack;
    logic    in_rom;
    logic    in_ram;

    // pass a request on with strobes forced low unless selected
    function automatic wb_req_t gate_req(input wb_req_t req, input logic sel);
        wb_req_t gated;
        gated     = req;
        gated.cyc = req.cyc && sel;
        gated.stb = req.stb && sel;
        return gated;
    endfunction

    // unsigned offset compare covers both bounds
    assign in_rom = ((bus_req.adr - rom_base) < rom_size) && (bus_req.adr < mem_top);
    assign in_ram = ((bus_req.adr - ram_base) < ram_size) && (bus_req.adr < mem_top);

    always_comb begin
        if (in_rom) begin
            region = region_rom;
        end else if (in_ram) begin
            region = region_ram;
        end else if (bus_req.adr == key_data_addr || bus_req.adr == key_stat_addr) begin
            region = region_key;
        end else if (bus_req.adr == uart_data_addr || bus_req.adr == uart_stat_addr) begin
            region = region_uart;
        end else begin
            region = region_none;
        end
    end

    // memory serves both rom and ram
    assign mem_req  = gate_req(bus_req, region == region_rom || region == region_ram);
    assign key_req  = gate_req(bus_req, region == region_key);
    assign uart_req = gate_req(bus_req, region == region_uart);

    // unmapped space answers itself with a single ack
    assign none_stb = bus_req.cyc && bus_req.stb && (region == region_none);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= none_stb && !none_ack;
        end
    end

    // request is held through the ack cycle, so region still selects
    always_comb begin
        case (region)
            region_rom,
            region_ram:  bus_rsp = mem_rsp;
            region_key:  bus_rsp = key_rsp;
            region_uart: bus_rsp = uart_rsp;
            default: begin
                bus_rsp.dat = 32'h0;
                bus_rsp.ack = none_ack;
            end
        endcase
    end

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter import board_pkg::*; (
    input  logic    CLOCK_50,
    input  logic    KEY0,
    input  wb_req_t fetch_req,
    input  wb_req_t data_req,
    output wb_rsp_t fetch_rsp,
    output wb_rsp_t data_rsp,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    // bus currently granted
    logic owned;
    // granted master, 0 fetch and 1 data
    logic owner;
    // last master that won, loses the next tie
    logic last_win;
    logic owner_cyc;
    logic bus_free;
    logic winner;
    logic any_cyc;

    assign owner_cyc = owner ? data_req.cyc : fetch_req.cyc;

    // owner dropping cyc frees the bus in that same cycle
    assign bus_free = !owned || !owner_cyc;
    assign any_cyc = fetch_req.cyc || data_req.cyc;

    // round robin on a tie, otherwise whoever asks
    assign winner = (fetch_req.cyc && data_req.cyc) ? ~last_win : data_req.cyc;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            owned    <= 1'b0;
            owner    <= 1'b0;
            last_win <= 1'b0;
        end else if (bus_free) begin
            owned <= any_cyc;
            if (any_cyc) begin
                owner    <= winner;
                last_win <= winner;
            end
        end
    end

    // forward the owner only, idle bus otherwise
    always_comb begin
        if (!owned) begin
            bus_req = '0;
        end else if (owner) begin
            bus_req = data_req;
        end else begin
            bus_req = fetch_req;
        end
    end

    // read data fans out, ack goes to the owner only
    always_comb begin
        fetch_rsp     = bus_rsp;
        data_rsp      = bus_rsp;
        fetch_rsp.ack = bus_rsp.ack && owned && !owner;
        data_rsp.ack  = bus_rsp.ack && owned && owner;
    end

endmodule

// ==== rtl/board_pkg.sv ====
package board_pkg;

    // wishbone classic request, master side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // wishbone classic response, slave side
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_rsp_t;

    // regions seen by the address decoder
    typedef enum logic [2:0] {
        region_rom,
        region_ram,
        region_key,
        region_uart,
        region_none
    } region_e;

    // boot image, writes are acked and dropped
    localparam logic [31:0] rom_base = 32'h0000_0000;
    localparam logic [31:0] rom_size = 32'h0000_1000;

    // writable ram right after the boot image
    localparam logic [31:0] ram_base = 32'h0000_1000;
    localparam logic [31:0] ram_size = 32'h0000_2000;

    // keyboard registers
    localparam logic [31:0] key_data_addr = 32'h0000_3000;
    localparam logic [31:0] key_stat_addr = 32'h0000_3004;

    // uart registers
    localparam logic [31:0] uart_data_addr = 32'h0000_3010;
    localparam logic [31:0] uart_stat_addr = 32'h0000_3014;

    // ps2 receiver, done waits for the stop bit
    typedef enum logic [1:0] {
        ps2_idle,
        ps2_data,
        ps2_parity,
        ps2_done
    } ps2_state_e;

    // uart transmitter, start bit goes out with the data bits
    typedef enum logic [1:0] {
        uart_idle,
        uart_data,
        uart_stop,
        uart_done
    } uart_state_e;

endpackage
